// File: include/trigger_params.svh
// widths and constants of the acquisition and trigger controller
`ifndef TRIGGER_PARAMS_SVH
`define TRIGGER_PARAMS_SVH

// one signed ADC sample
`define SAMPLE_W 12

// samples delivered on every clklvds edge
`define SAMPLES_PER_CLK 40

`define RAM_ADDR_W 10 // circular sample RAM, 1024 words

`define LEN_W 16 // pre and post trigger write counters

// writes between the back-panel edge and the sample it belongs to
`define EXT_TRIG_DELAY 3

`define DOWNSAMPLE_W 5 // exponent, clocks per tick = 2**downsample

`define MERGE_W 8 // ticks merged into one RAM write

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the trigger controller simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f sources.f --top-module tb_trigger -Mdir obj_dir -o tb_trigger
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

out=$(./obj_dir/tb_trigger 2>&1)
sim_status=$?
echo "$out"

if [ $sim_status -ne 0 ]; then
   echo "simulation ended with an error status"
   exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
   exit 0
fi

echo "pass message not found"
exit 1

// File: source/acq_fsm.sv
// acquisition state machine with pre/post counters, time over threshold and trigger records
`timescale 1ns/100ps
`default_nettype none

`include "trigger_params.svh"

module acq_fsm import trigger_pkg::*; (
   input  logic                   clklvds,
   input  logic                   reset,
   input  acq_config_t            cfg,
   input  logic                   lvds_fwd_in,
   input  logic                   lvdsin_trig_b,
   input  logic                   ext_level,
   input  logic                   ext_rise,
   input  logic                   arm_hit,
   input  logic                   fire_hit,
   input  logic [`RAM_ADDR_W-1:0] ram_wr_address,
   input  logic                   write_tick,
   input  logic [`MERGE_W-1:0]    merge_phase,
   output logic                   write_en,
   output logic                   rising,
   output acq_status_t            status,
   output trig_out_t              trig_out
);

   acq_state_t             state;
   acq_state_t             state_next;
   trig_kind_t             kind_latched;  // kind the current run was armed with
   logic [`LEN_W-1:0]      trig_cnt;      // pre, then post trigger writes
   logic [7:0]             tot_cnt;
   logic                   ext_armed;
   logic                   ext_armed_now;
   logic                   phase_seen;    // first fire seen in edge_fire
   logic [`MERGE_W-1:0]    phase_hold;
   logic                   first_post;
   logic [31:0]            cycle_cnt;
   logic [31:0]            event_counter;
   logic [31:0]            event_time;
   logic [`RAM_ADDR_W-1:0] addr_trig;
   logic [`MERGE_W-1:0]    phase_trig;
   logic                   abort;
   logic                   fire;
   logic                   fire_fwd;
   logic                   fire_bwd;
   logic                   fire_ext;

   assign abort         = cfg.trigger_kind != kind_latched;
   assign ext_armed_now = ext_armed | ext_rise;
   assign write_en      = (state != st_idle) && (state != st_readout);

   always_comb begin
      state_next = state;
      fire       = 1'b0;
      fire_fwd   = 1'b1;
      fire_bwd   = 1'b1;
      fire_ext   = 1'b0;
      case (state)
         st_idle: begin
            if (cfg.trigger_kind != trig_none && cfg.trigger_live) state_next = st_pre_acq;
         end
         st_pre_acq: begin
            if (abort) begin
               state_next = st_idle;
            end else if (trig_cnt >= cfg.pre_length) begin
               case (kind_latched)
                  trig_rise, trig_fall: state_next = st_edge_arm;
                  trig_lvds:            state_next = st_lvds_wait;
                  trig_auto:            state_next = st_force_trig;
                  trig_ext:             state_next = st_ext_wait;
                  default:              state_next = st_idle; // unknown code
               endcase
            end
         end
         st_edge_arm: begin
            if (abort) state_next = st_idle;
            else if (arm_hit) state_next = st_edge_fire;
         end
         st_edge_fire: begin
            if (abort) state_next = st_idle;
            else fire = fire_hit && (tot_cnt >= cfg.tot);
         end
         st_lvds_wait: begin
            if (abort) begin
               state_next = st_idle;
            end else begin
               fire     = lvds_fwd_in | lvdsin_trig_b;
               fire_fwd = lvds_fwd_in;   // pass the trigger on in the direction it came
               fire_bwd = lvdsin_trig_b;
            end
         end
         st_force_trig: fire = 1'b1;
         st_ext_wait: begin
            if (abort) begin
               state_next = st_idle;
            end else begin
               fire     = ext_armed_now && (tot_cnt >= cfg.tot);
               fire_ext = 1'b1;
            end
         end
         st_post_acq: begin
            if (trig_cnt >= cfg.length_to_take) state_next = st_readout;
         end
         st_readout: begin
            if (cfg.did_readout) state_next = st_idle;
         end
         default: state_next = st_idle;
      endcase
      if (fire) state_next = st_post_acq;
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         state         <= st_idle;
         kind_latched  <= trig_none;
         trig_cnt      <= '0;
         tot_cnt       <= '0;
         ext_armed     <= 1'b0;
         phase_seen    <= 1'b0;
         phase_hold    <= '0;
         first_post    <= 1'b0;
         rising        <= 1'b0;
         cycle_cnt     <= '0;
         event_counter <= '0;
         event_time    <= '0;
         addr_trig     <= '0;
         phase_trig    <= '0;
         trig_out      <= '0;
      end else begin
         state     <= state_next;
         cycle_cnt <= cycle_cnt + 1'b1;
         case (state)
            st_idle: begin
               kind_latched <= cfg.trigger_kind;
               trig_cnt     <= '0;
               tot_cnt      <= '0;
               ext_armed    <= 1'b0;
               phase_seen   <= 1'b0;
            end
            st_pre_acq: begin
               if (trig_cnt < cfg.pre_length) begin
                  if (write_tick) trig_cnt <= trig_cnt + 1'b1;
               end else begin
                  trig_cnt <= '0; // reused for the post trigger count
                  rising   <= kind_latched == trig_rise;
               end
            end
            st_edge_fire: begin
               if (fire_hit) begin
                  if (write_tick) tot_cnt <= tot_cnt + 1'b1;
                  if (!phase_seen) begin
                     phase_seen <= 1'b1;
                     phase_hold <= merge_phase;
                  end
               end
            end
            st_ext_wait: begin
               ext_armed <= ext_armed_now;
               // count while the line stays high, start over when it drops
               tot_cnt <= (ext_armed_now && ext_level) ? tot_cnt + 1'b1 : '0;
            end
            st_post_acq: begin
               if (first_post) begin
                  first_post <= 1'b0;
                  event_time <= cycle_cnt;
               end else begin
                  trig_out.lvds_fwd <= 1'b0; // neighbours have had two clocks
                  trig_out.lvds_bwd <= 1'b0;
               end
               if (trig_cnt < cfg.length_to_take) begin
                  if (write_tick) trig_cnt <= trig_cnt + 1'b1;
               end else begin
                  event_counter <= event_counter + 1'b1;
                  trig_cnt      <= '0;
                  trig_out      <= '0;
               end
            end
            default: ;
         endcase
         if (fire) begin
            addr_trig <= ram_wr_address - `RAM_ADDR_W'(cfg.tot)
                       + (fire_ext ? `RAM_ADDR_W'(`EXT_TRIG_DELAY) : '0);
            // edge triggers keep the phase of their first fire
            phase_trig <= (state == st_edge_fire && phase_seen) ? phase_hold : merge_phase;
            trig_out.lvds_fwd <= fire_fwd;
            trig_out.lvds_bwd <= fire_bwd;
            trig_out.aux      <= 1'b1;
            first_post        <= 1'b1;
            trig_cnt          <= '0;
         end
      end
   end

   assign status = '{
      state:                 state,
      event_counter:         event_counter,
      ram_address_triggered: addr_trig,
      merge_phase_triggered: phase_trig,
      event_time:            event_time
   };

   // trigger-out to the neighbours only while post-trigger data is taken
   assert property (@(posedge clklvds) disable iff (reset)
      trig_out.lvds_fwd |-> state == st_post_acq);

   assert property (@(posedge clklvds) disable iff (reset)
      1'b1 |=> state inside {st_idle, st_pre_acq, st_edge_arm, st_edge_fire, st_lvds_wait,
                             st_force_trig, st_ext_wait, st_post_acq, st_readout});

endmodule

`default_nettype wire

// File: source/config_sync.sv
// input register stage for host settings, samples and trigger lines, external edge detect
`timescale 1ns/100ps
`default_nettype none

`include "trigger_params.svh"

module config_sync import trigger_pkg::*; (
   input  logic        clklvds,
   input  logic        reset,
   input  acq_config_t cfg_in,
   input  sample_vec_t samples_in,
   input  logic        lvdsin_trig,
   input  logic        exttrigin,
   output acq_config_t cfg,
   output sample_vec_t samples,
   output logic        lvds_fwd_in,
   output logic        ext_level,
   output logic        ext_rise
);

   logic ext_last; // ext_level one clock later

   // settings come from a slow host domain and only need one stage
   always_ff @(posedge clklvds) begin
      if (reset) begin
         cfg         <= '0;
         lvds_fwd_in <= 1'b0;
         ext_level   <= 1'b0;
         ext_last    <= 1'b0;
      end else begin
         cfg         <= cfg_in;
         lvds_fwd_in <= lvdsin_trig;
         ext_level   <= exttrigin;
         ext_last    <= ext_level;
      end
   end

   always_ff @(posedge clklvds) begin
      samples <= samples_in; // ADC data, realigned to clklvds
   end

   // high in the first clock that ext_level is seen high
   assign ext_rise = ext_level & ~ext_last;

endmodule

`default_nettype wire

// File: source/sample_decimator.sv
// downsample and merge counters producing the RAM write strobe and write address
`timescale 1ns/100ps
`default_nettype none

`include "trigger_params.svh"

module sample_decimator import trigger_pkg::*; (
   input  logic                     clklvds,
   input  logic                     reset,
   input  logic                     write_en,
   input  logic [`DOWNSAMPLE_W-1:0] downsample,
   input  logic [`MERGE_W-1:0]      merge,
   output logic                     ram_wr,
   output logic [`RAM_ADDR_W-1:0]   ram_wr_address,
   output logic                     write_tick,
   output logic [`MERGE_W-1:0]      merge_phase
);

   localparam int DS_CNT_W = 2 ** `DOWNSAMPLE_W;

   logic [DS_CNT_W-1:0] ds_cnt;    // runs 1 .. 2**downsample
   logic [`MERGE_W-1:0] merge_cnt; // runs 1 .. merge
   logic                ds_tick;

   assign ds_tick     = ds_cnt[downsample];
   assign write_tick  = write_en && ds_tick && (merge_cnt == merge);
   assign merge_phase = merge_cnt;

   always_ff @(posedge clklvds) begin
      if (reset) begin
         ds_cnt         <= DS_CNT_W'(1);
         merge_cnt      <= `MERGE_W'(1);
         ram_wr         <= 1'b0;
         ram_wr_address <= '0;
      end else if (!write_en) begin
         ds_cnt    <= DS_CNT_W'(1); // address is kept, so the ring continues
         merge_cnt <= `MERGE_W'(1);
         ram_wr    <= 1'b0;
      end else begin
         ram_wr <= write_tick;
         if (ds_tick) begin
            ds_cnt <= DS_CNT_W'(1);
            if (write_tick) begin
               merge_cnt      <= `MERGE_W'(1);
               ram_wr_address <= ram_wr_address + 1'b1; // wraps at 1024
            end else begin
               merge_cnt <= merge_cnt + 1'b1;
            end
         end else begin
            ds_cnt <= ds_cnt + 1'b1;
         end
      end
   end

   // the RAM must not be written by a strobe left over from an idle cycle
   assert property (@(posedge clklvds) disable iff (reset)
      !$past(write_en) |-> !ram_wr);

endmodule

`default_nettype wire

// File: source/threshold_detector.sv
// parallel threshold compare of all samples per clock, registered arm and fire hits
`timescale 1ns/100ps
`default_nettype none

`include "trigger_params.svh"

module threshold_detector import trigger_pkg::*; (
   input  logic        clklvds,
   input  logic        reset,
   input  sample_vec_t samples,
   input  sample_t     lower_thresh,
   input  sample_t     upper_thresh,
   input  logic        rising,
   output logic        arm_hit,
   output logic        fire_hit
);

   logic [`SAMPLES_PER_CLK-1:0] below; // per sample, under lower_thresh
   logic [`SAMPLES_PER_CLK-1:0] above; // per sample, over upper_thresh
   logic                        any_below;
   logic                        any_above;

   // signed compare, sample_t carries the sign
   always_comb begin
      for (int i = 0; i < `SAMPLES_PER_CLK; i++) begin
         below[i] = samples[i] < lower_thresh;
         above[i] = samples[i] > upper_thresh;
      end
   end

   assign any_below = |below;
   assign any_above = |above;

   // a rising edge arms low and fires high, a falling edge is the mirror
   always_ff @(posedge clklvds) begin
      if (reset) begin
         arm_hit  <= 1'b0;
         fire_hit <= 1'b0;
      end else begin
         arm_hit  <= rising ? any_below : any_above;
         fire_hit <= rising ? any_above : any_below;
      end
   end

endmodule

`default_nettype wire

// File: source/trigger_pkg.sv
// state, trigger-kind, settings, status and trigger-out types
`default_nettype none

`include "trigger_params.svh"

package trigger_pkg;

   typedef enum logic [3:0] {
      st_idle,
      st_pre_acq,
      st_edge_arm,
      st_edge_fire,
      st_lvds_wait,
      st_force_trig,
      st_ext_wait,
      st_post_acq,
      st_readout
   } acq_state_t;

   // codes as written by the host
   typedef enum logic [7:0] {
      trig_none = 8'd0,
      trig_rise = 8'd1,
      trig_fall = 8'd2,
      trig_lvds = 8'd3,
      trig_auto = 8'd4,
      trig_ext  = 8'd5
   } trig_kind_t;

   typedef logic signed [`SAMPLE_W-1:0] sample_t;

   typedef sample_t [`SAMPLES_PER_CLK-1:0] sample_vec_t;

   typedef struct packed {
      sample_t                  lower_thresh;
      sample_t                  upper_thresh;
      logic [`LEN_W-1:0]        length_to_take; // writes after the trigger
      logic [`LEN_W-1:0]        pre_length;     // writes before arming
      trig_kind_t               trigger_kind;
      logic [7:0]               tot;            // time over threshold
      logic [`DOWNSAMPLE_W-1:0] downsample;
      logic [`MERGE_W-1:0]      merge;
      logic                     trigger_live;
      logic                     did_readout;
   } acq_config_t;

   typedef struct packed {
      acq_state_t            state;
      logic [31:0]           event_counter;
      logic [`RAM_ADDR_W-1:0] ram_address_triggered;
      logic [`MERGE_W-1:0]   merge_phase_triggered;
      logic [31:0]           event_time;
   } acq_status_t;

   typedef struct packed {
      logic lvds_fwd;
      logic lvds_bwd;
      logic aux; // back panel, plain level
   } trig_out_t;

endpackage

`default_nettype wire

// File: source/trigger_top.sv
// top level of the acquisition and trigger controller
`timescale 1ns/100ps
`default_nettype none

`include "trigger_params.svh"

module trigger_top import trigger_pkg::*; (
   input  logic                   clklvds,
   input  logic                   reset,
   input  acq_config_t            cfg_in,
   input  sample_vec_t            samples_in,
   input  logic                   lvdsin_trig,
   input  logic                   lvdsin_trig_b,
   input  logic                   exttrigin,
   output logic                   ram_wr,
   output logic [`RAM_ADDR_W-1:0] ram_wr_address,
   output acq_status_t            status,
   output trig_out_t              trig_out
);

   acq_config_t         cfg;
   sample_vec_t         samples;
   logic                lvds_fwd_in;
   logic                ext_level;
   logic                ext_rise;
   logic                write_en;
   logic                write_tick;
   logic [`MERGE_W-1:0] merge_phase;
   logic                rising;
   logic                arm_hit;
   logic                fire_hit;

   config_sync u_config_sync (
      .clklvds     (clklvds),
      .reset       (reset),
      .cfg_in      (cfg_in),
      .samples_in  (samples_in),
      .lvdsin_trig (lvdsin_trig),
      .exttrigin   (exttrigin),
      .cfg         (cfg),
      .samples     (samples),
      .lvds_fwd_in (lvds_fwd_in),
      .ext_level   (ext_level),
      .ext_rise    (ext_rise)
   );

   sample_decimator u_sample_decimator (
      .clklvds        (clklvds),
      .reset          (reset),
      .write_en       (write_en),
      .downsample     (cfg.downsample),
      .merge          (cfg.merge),
      .ram_wr         (ram_wr),
      .ram_wr_address (ram_wr_address),
      .write_tick     (write_tick),
      .merge_phase    (merge_phase)
   );

   threshold_detector u_threshold_detector (
      .clklvds      (clklvds),
      .reset        (reset),
      .samples      (samples),
      .lower_thresh (cfg.lower_thresh),
      .upper_thresh (cfg.upper_thresh),
      .rising       (rising),
      .arm_hit      (arm_hit),
      .fire_hit     (fire_hit)
   );

   // backward line is taken as it arrives
   acq_fsm u_acq_fsm (
      .clklvds        (clklvds),
      .reset          (reset),
      .cfg            (cfg),
      .lvds_fwd_in    (lvds_fwd_in),
      .lvdsin_trig_b  (lvdsin_trig_b),
      .ext_level      (ext_level),
      .ext_rise       (ext_rise),
      .arm_hit        (arm_hit),
      .fire_hit       (fire_hit),
      .ram_wr_address (ram_wr_address),
      .write_tick     (write_tick),
      .merge_phase    (merge_phase),
      .write_en       (write_en),
      .rising         (rising),
      .status         (status),
      .trig_out       (trig_out)
   );

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
source/trigger_pkg.sv
source/config_sync.sv
source/sample_decimator.sv
source/threshold_detector.sv
source/acq_fsm.sv
source/trigger_top.sv
testbench/tb_trigger.sv

// File: testbench/tb_trigger.sv
// testbench for trigger_top with LFSR stimulus, reference checks and timeout
`timescale 1ns/100ps
`default_nettype none

`include "trigger_params.svh"

module tb_trigger import trigger_pkg::*;;

   localparam int NUM_RUNS = 9;
   localparam int RUN_MAX  = (7 + 8 + 3) * 32 + 124; // longest pre + post + waits, in cycles
   localparam int LIMIT    = NUM_RUNS * RUN_MAX + 50;

   logic        clklvds;
   logic        reset;
   acq_config_t cfg_in;
   sample_vec_t samples_in;
   logic        lvdsin_trig;
   logic        lvdsin_trig_b;
   logic        exttrigin;
   logic        ram_wr;
   logic [`RAM_ADDR_W-1:0] ram_wr_address;
   acq_status_t status;
   trig_out_t   trig_out;

   logic [15:0] lfsr;
   int          cyc;          // own cycle count, 0 in the first cycle after reset
   int          error_count;
   int          period;       // expected clocks between RAM writes
   int          tick_len;     // clocks per downsample tick
   int          cur_pre;
   int          cur_len;
   int          cur_tot;
   logic        exp_fwd;
   logic        exp_bwd;
   logic        exp_ext;
   // monitor state
   acq_state_t  prev_state;
   logic [`RAM_ADDR_W-1:0] prev_addr;
   logic [`RAM_ADDR_W-1:0] next_addr;
   logic        have_pulse;
   int          last_pulse;
   int          phase_base;   // cycle in which the merge count was last at 1
   int          pre_ticks;
   int          post_ticks;
   int          post_idx;
   int          events_model;
   int          trig_time;

   trigger_top i_dut (
      .clklvds        (clklvds),
      .reset          (reset),
      .cfg_in         (cfg_in),
      .samples_in     (samples_in),
      .lvdsin_trig    (lvdsin_trig),
      .lvdsin_trig_b  (lvdsin_trig_b),
      .exttrigin      (exttrigin),
      .ram_wr         (ram_wr),
      .ram_wr_address (ram_wr_address),
      .status         (status),
      .trig_out       (trig_out)
   );

   initial begin
      clklvds = 1'b0;
      forever #2 clklvds = ~clklvds;
   end

   // 16 bit Fibonacci, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         error_count++;
         $display("error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1);
      end
   endtask

   task automatic wait_for_state(input acq_state_t st, input int limit);
      int n;
      n = 0;
      while (status.state != st) begin
         @(negedge clklvds);
         n++;
         if (n > limit) fail_run($sformatf("state %s was not reached in time", st.name()));
      end
   endtask

   // mode 0 keeps every sample between the thresholds, 1 pushes some below, 2 above
   task automatic make_samples(input int mode);
      logic [31:0] v;
      logic [31:0] pick;
      for (int i = 0; i < `SAMPLES_PER_CLK; i++) begin
         rand_bits(8, v);
         rand_bits(1, pick);
         if (mode == 0 || (pick[0] && i != 0)) samples_in[i] <= sample_t'(int'(v) - 128);
         else if (mode == 1) samples_in[i] <= sample_t'(-300 - int'(v));
         else samples_in[i] <= sample_t'(300 + int'(v));
      end
   endtask

   task automatic start_run(input trig_kind_t kind, input int tot, input logic fwd,
                            input logic bwd, input logic ext);
      logic [31:0] ds;
      logic [31:0] mg;
      logic [31:0] pre;
      logic [31:0] len;
      rand_bits(2, ds);
      rand_bits(2, mg);
      rand_bits(3, pre);
      rand_bits(3, len);
      tick_len = 1 << ds;
      period   = (1 << ds) * (int'(mg) + 1);
      cur_pre  = int'(pre);
      cur_len  = int'(len) + 1;
      cur_tot  = tot;
      exp_fwd  = fwd;
      exp_bwd  = bwd;
      exp_ext  = ext;
      @(posedge clklvds);
      cfg_in.downsample     <= `DOWNSAMPLE_W'(ds);
      cfg_in.merge          <= `MERGE_W'(mg + 1);
      cfg_in.pre_length     <= `LEN_W'(cur_pre);
      cfg_in.length_to_take <= `LEN_W'(cur_len);
      cfg_in.tot            <= 8'(tot);
      cfg_in.trigger_kind   <= kind;
      cfg_in.did_readout    <= 1'b0;
      cfg_in.trigger_live   <= 1'b1;
   endtask

   task automatic finish_readout();
      wait_for_state(st_readout, RUN_MAX);
      @(posedge clklvds);
      cfg_in.did_readout  <= 1'b1;
      cfg_in.trigger_live <= 1'b0;
      wait_for_state(st_idle, 8);
      @(posedge clklvds);
      cfg_in.did_readout <= 1'b0;
   endtask

   always @(posedge clklvds) begin
      if (reset) cyc <= 0;
      else cyc <= cyc + 1;
      if (cyc > LIMIT) fail_run("the run took longer than its cycle limit");
   end

   // reference model of write schedule, trigger records and trigger-out levels
   always @(negedge clklvds) begin
      acq_state_t st;
      logic [`RAM_ADDR_W-1:0] exp_addr;
      if (!reset) begin
         st = status.state;
         if (st == st_idle) have_pulse = 1'b0;
         if (prev_state == st_idle && st == st_pre_acq) begin
            pre_ticks  = 0;
            phase_base = cyc; // counters leave idle at their start value
         end
         if (prev_state == st_pre_acq && st != st_pre_acq && st != st_idle)
            check_value("pre_acq write ticks", pre_ticks, cur_pre);
         if (prev_state != st_post_acq && st == st_post_acq) begin
            exp_addr = prev_addr - `RAM_ADDR_W'(cur_tot)
                     + (exp_ext ? `RAM_ADDR_W'(`EXT_TRIG_DELAY) : '0);
            check_value("ram_address_triggered", status.ram_address_triggered, exp_addr);
            check_value("merge_phase_triggered", status.merge_phase_triggered,
                        1 + (cyc - 1 - phase_base) / tick_len);
            post_ticks = 0;
            post_idx   = 0;
            trig_time  = cyc;
         end
         if (prev_state == st_post_acq && st == st_readout) begin
            check_value("post_acq write ticks", post_ticks, cur_len);
            check_value("event_time", status.event_time, trig_time);
            events_model++;
         end
         check_value("event_counter", status.event_counter, events_model);
         if (ram_wr) begin
            check_value("ram_wr after idle or readout",
                        prev_state == st_idle || prev_state == st_readout, 0);
            check_value("ram_wr_address", ram_wr_address, next_addr);
            if (have_pulse) check_value("ram_wr spacing", cyc - last_pulse, period);
            next_addr  = ram_wr_address + 1'b1;
            have_pulse = 1'b1;
            last_pulse = cyc;
            phase_base = cyc;
            if (prev_state == st_pre_acq && st == st_pre_acq) pre_ticks++;
            if (prev_state == st_post_acq && st == st_post_acq) post_ticks++;
         end
         if (st == st_post_acq) begin
            post_idx++;
            check_value("lvds_fwd", trig_out.lvds_fwd, post_idx <= 2 ? exp_fwd : 1'b0);
            check_value("lvds_bwd", trig_out.lvds_bwd, post_idx <= 2 ? exp_bwd : 1'b0);
         end else begin
            check_value("lvds_fwd", trig_out.lvds_fwd, 0);
            check_value("lvds_bwd", trig_out.lvds_bwd, 0);
         end
         check_value("aux", trig_out.aux, st == st_post_acq);
         prev_state = st;
         prev_addr  = ram_wr_address;
      end
   end

   task automatic edge_run(input trig_kind_t kind);
      start_run(kind, 0, 1'b1, 1'b1, 1'b0);
      wait_for_state(st_edge_arm, RUN_MAX);
      @(posedge clklvds);
      make_samples(kind == trig_rise ? 1 : 2);
      wait_for_state(st_edge_fire, 8);
      @(posedge clklvds);
      make_samples(kind == trig_rise ? 2 : 1);
      wait_for_state(st_post_acq, 8);
      @(posedge clklvds);
      make_samples(0);
      finish_readout();
   endtask

   task automatic lvds_run(input logic forward);
      start_run(trig_lvds, 0, forward, !forward, 1'b0);
      wait_for_state(st_lvds_wait, RUN_MAX);
      @(posedge clklvds);
      if (forward) lvdsin_trig <= 1'b1;
      else lvdsin_trig_b <= 1'b1;
      @(posedge clklvds);
      lvdsin_trig   <= 1'b0;
      lvdsin_trig_b <= 1'b0;
      wait_for_state(st_post_acq, 8);
      finish_readout();
   endtask

   task automatic ext_run();
      logic [31:0] r;
      int tot;
      int width;
      rand_bits(3, r);
      tot = int'(r) + 2;
      start_run(trig_ext, tot, 1'b1, 1'b1, 1'b1);
      wait_for_state(st_ext_wait, RUN_MAX);
      rand_bits(3, r);
      width = 1 + (int'(r) % (tot - 1)); // shorter than tot
      @(posedge clklvds);
      exttrigin <= 1'b1;
      repeat (width) @(posedge clklvds);
      exttrigin <= 1'b0;
      repeat (2 * tot + 4) begin
         @(negedge clklvds);
         check_value("state after short pulse", status.state, st_ext_wait);
      end
      @(posedge clklvds);
      exttrigin <= 1'b1;
      repeat (tot + 3) @(posedge clklvds);
      exttrigin <= 1'b0;
      wait_for_state(st_post_acq, 8);
      finish_readout();
   endtask

   initial begin
      logic [31:0] r;
      lfsr          = 16'd95;
      error_count   = 0;
      period        = 1;
      tick_len      = 1;
      cur_pre       = 0;
      cur_len       = 0;
      cur_tot       = 0;
      exp_fwd       = 1'b0;
      exp_bwd       = 1'b0;
      exp_ext       = 1'b0;
      prev_state    = st_idle;
      prev_addr     = '0;
      next_addr     = 1;
      have_pulse    = 1'b0;
      last_pulse    = 0;
      phase_base    = 0;
      pre_ticks     = 0;
      post_ticks    = 0;
      post_idx      = 0;
      events_model  = 0;
      trig_time     = 0;
      reset         = 1'b1;
      cfg_in        = '0;
      cfg_in.lower_thresh = -12'sd200;
      cfg_in.upper_thresh = 12'sd200;
      cfg_in.merge        = 1;
      samples_in    = '0;
      lvdsin_trig   = 1'b0;
      lvdsin_trig_b = 1'b0;
      exttrigin     = 1'b0;
      repeat (4) @(posedge clklvds);
      reset <= 1'b0;
      @(negedge clklvds);
      check_value("state", status.state, st_idle);
      check_value("ram_wr", ram_wr, 0);
      check_value("trig_out", trig_out, 0);
      check_value("event_time", status.event_time, 0);
      @(posedge clklvds);
      make_samples(0);
      for (int i = 0; i < 3; i++) begin
         rand_bits(3, r);
         start_run(trig_auto, int'(r), 1'b1, 1'b1, 1'b0);
         finish_readout();
      end
      edge_run(trig_rise);
      edge_run(trig_fall);
      lvds_run(1'b1);
      lvds_run(1'b0);
      ext_run();
      // abort from a waiting state, nothing may be counted
      start_run(trig_ext, 8, 1'b1, 1'b1, 1'b1);
      wait_for_state(st_ext_wait, RUN_MAX);
      @(posedge clklvds);
      cfg_in.trigger_kind <= trig_none;
      wait_for_state(st_idle, 6);
      @(posedge clklvds);
      cfg_in.trigger_live <= 1'b0;
      repeat (10) @(negedge clklvds);
      check_value("state after abort", status.state, st_idle);
      check_value("event_counter after abort", status.event_counter, 8);
      if (error_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
